/* alu.sv */
`default_nettype none
`timescale 1ns/10ps

`include "cpu16_settings.svh"

module alu (
	input  cpu16Pkg::word_t   a,
	input  cpu16Pkg::word_t   b,
	input  cpu16Pkg::opcode_t opcode,
	input  logic              carryIn,
	output cpu16Pkg::word_t   result,
	output cpu16Pkg::flags_t  flags
);
	import cpu16Pkg::*;

	localparam int msb = `CPU16_DATA_WIDTH - 1;

	// Two's complement of B, SUB adds this
	word_t bNeg;

	assign bNeg = -b;

	always_comb
	begin
		// NOP and undefined codes leave everything at zero
		result = '0;
		flags  = '0;
		case (opcode)
			////////////////////////////////////////////////////////////////////
			// Arithmetic
			////////////////////////////////////////////////////////////////////
			ADD:
			begin
				result         = a + b;
				flags.zero     = (result == '0);
				flags.flag     = (~a[msb] & ~b[msb] & result[msb]) |
					(a[msb] & b[msb] & ~result[msb]);
				// Carry stays clear for signed add
				flags.low      = $signed(a) < $signed(b);
				flags.negative = result[msb];
			end
			ADDU:
			begin
				{flags.carry, result} = a + b;
				flags.zero = (result == '0);
				flags.low  = a < b;
			end
			ADDCU:
			begin
				{flags.carry, result} = a + b + carryIn;
				// Zero only when the carry out is clear as well
				flags.zero = (result == '0) && !flags.carry;
				flags.low  = a < b;
			end
			SUB:
			begin
				result         = a + bNeg;
				flags.zero     = (a == b);
				flags.flag     = (~a[msb] & ~bNeg[msb] & result[msb]) |
					(a[msb] & bNeg[msb] & ~result[msb]);
				flags.low      = $signed(a) < $signed(b);
				flags.negative = result[msb];
			end
			CMP:
			begin
				// Flags only, result stays zero
				flags.low      = a < b;
				flags.negative = $signed(a) < $signed(b);
				flags.zero     = (a == b);
			end
			////////////////////////////////////////////////////////////////////
			// Logic
			////////////////////////////////////////////////////////////////////
			TEST:
			begin
				result         = a & b;
				flags.zero     = (result == '0);
				flags.low      = a < b;
				flags.negative = $signed(a) < $signed(b);
			end
			AND:
			begin
				result         = a & b;
				flags.zero     = (result == '0);
				flags.low      = a < b;
				flags.negative = result[msb];
			end
			OR:
			begin
				result         = a | b;
				flags.zero     = (result == '0);
				flags.low      = a < b;
				flags.negative = result[msb];
			end
			XOR:
			begin
				result         = a ^ b;
				flags.zero     = (result == '0);
				flags.low      = a < b;
				flags.negative = result[msb];
			end
			NOT:
			begin
				result         = ~a;
				flags.zero     = (result == '0);
				// Low compares the inverted value against A
				flags.low      = result < a;
				flags.negative = result[msb];
			end
			////////////////////////////////////////////////////////////////////
			// Shifts, zero flag only
			////////////////////////////////////////////////////////////////////
			LSH, ALSH:
			begin
				result     = a << b;
				flags.zero = (result == '0);
			end
			RSH:
			begin
				result     = a >> b;
				flags.zero = (result == '0);
			end
			ARSH:
			begin
				// Amount wraps to the low four bits
				result     = $signed(a) >>> b[3:0];
				flags.zero = (result == '0);
			end
			default:
			begin
				result = '0;
				flags  = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* cpu16Exec.sv */
`default_nettype none
`timescale 1ns/10ps

module cpu16Exec (
	input  logic               clk,
	input  logic               arstN,
	input  logic               instrValid,
	input  cpu16Pkg::word_t    instr,
	output logic               wbValid,
	output cpu16Pkg::regAddr_t wbAddr,
	output cpu16Pkg::word_t    wbData,
	output logic               wbWrite,
	output cpu16Pkg::flags_t   psr
);
	import cpu16Pkg::*;

	decoded_t decoded;
	word_t    readDataA;
	word_t    readDataB;
	word_t    operandB;
	word_t    aluResult;
	flags_t   aluFlags;
	logic     writeEn;
	regAddr_t writeAddr;
	word_t    writeData;

	instrDecoder i_instrDecoder (
		.instr   (instr),
		.decoded (decoded)
	);

	regFile i_regFile (
		.clk       (clk),
		.arstN     (arstN),
		.readAddrA (decoded.rDest),
		.readAddrB (decoded.rSrc),
		.readDataA (readDataA),
		.readDataB (readDataB),
		.writeEn   (writeEn),
		.writeAddr (writeAddr),
		.writeData (writeData)
	);

	// ADDI takes B from the immediate
	assign operandB = decoded.useImm ? decoded.imm : readDataB;

	alu i_alu (
		.a       (readDataA),
		.b       (operandB),
		.opcode  (decoded.op),
		.carryIn (psr.carry),
		.result  (aluResult),
		.flags   (aluFlags)
	);

	writeback i_writeback (
		.clk        (clk),
		.arstN      (arstN),
		.instrValid (instrValid),
		.decoded    (decoded),
		.aluResult  (aluResult),
		.aluFlags   (aluFlags),
		.writeEn    (writeEn),
		.writeAddr  (writeAddr),
		.writeData  (writeData),
		.wbValid    (wbValid),
		.wbWrite    (wbWrite),
		.wbAddr     (wbAddr),
		.wbData     (wbData),
		.psr        (psr)
	);

endmodule

`default_nettype wire

/* cpu16Exec_chk.sv */
`default_nettype none
`timescale 1ns/10ps

module cpu16ExecChk (
	input logic             clk,
	input logic             arstN,
	input logic             instrValid,
	input logic             wbValid,
	input logic             wbWrite,
	input cpu16Pkg::flags_t psr
);

	// Report pulse trails each strobe by one cycle
	validFollows: assert property (@(posedge clk) disable iff (!arstN)
		wbValid == $past(instrValid))
		else $error("wbValid does not follow instrValid by one cycle");

	writeImpliesValid: assert property (@(posedge clk) disable iff (!arstN)
		wbWrite |-> wbValid)
		else $error("wbWrite high without wbValid");

	// No strobe, no status change
	psrHolds: assert property (@(posedge clk) disable iff (!arstN)
		!instrValid |=> $stable(psr))
		else $error("psr changed after an idle cycle");

endmodule

bind cpu16Exec cpu16ExecChk i_cpu16ExecChk (
	.clk        (clk),
	.arstN      (arstN),
	.instrValid (instrValid),
	.wbValid    (wbValid),
	.wbWrite    (wbWrite),
	.psr        (psr)
);

`default_nettype wire

/* cpu16Exec_tb.sv */
`default_nettype none
`timescale 1ns/10ps

`include "cpu16_settings.svh"

module cpu16Exec_tb;
	import cpu16Pkg::*;

	localparam int clkPeriod   = 8;
	localparam int msb         = `CPU16_DATA_WIDTH - 1;
	localparam int shiftCount  = 84;
	localparam int randomCount = 600;
	// Twice the longest expected run in cycles
	localparam int cycleBudget = 2 * (200 + 7 * shiftCount + 3 * randomCount);

	typedef struct packed {
		word_t  result;
		flags_t flags;
	} aluOut_t;

	// Expected report and PSR for the next check
	typedef struct packed {
		logic     valid;
		logic     write;
		regAddr_t addr;
		word_t    data;
		flags_t   psr;
	} report_t;

	logic     clk = 1'b0;
	logic     arstN;
	logic     instrValid;
	word_t    instr;
	logic     wbValid;
	regAddr_t wbAddr;
	word_t    wbData;
	logic     wbWrite;
	flags_t   psr;

	logic [31:0] lfsrState;
	word_t       regModel [`CPU16_REG_COUNT];
	report_t     expected;
	int          errorCount;

	cpu16Exec i_cpu16Exec (
		.clk        (clk),
		.arstN      (arstN),
		.instrValid (instrValid),
		.instr      (instr),
		.wbValid    (wbValid),
		.wbAddr     (wbAddr),
		.wbData     (wbData),
		.wbWrite    (wbWrite),
		.psr        (psr)
	);

	always #(clkPeriod / 2) clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] randBits(int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	function automatic word_t regInstr(opcode_t op, int rd, int rs);
		return {op[7:4], rd[3:0], op[3:0], rs[3:0]};
	endfunction

	function automatic word_t immInstr(logic [3:0] major, int rd, logic [7:0] imm);
		return {major, rd[3:0], imm};
	endfunction

	// Indices 10 to 13 are the shifts
	function automatic opcode_t pickRegOp(logic [3:0] sel);
		case (sel)
			4'd0:    return AND;
			4'd1:    return OR;
			4'd2:    return XOR;
			4'd3:    return ADD;
			4'd4:    return ADDU;
			4'd5:    return ADDCU;
			4'd6:    return TEST;
			4'd7:    return SUB;
			4'd8:    return NOT;
			4'd9:    return CMP;
			4'd10:   return LSH;
			4'd11:   return RSH;
			4'd12:   return ALSH;
			4'd13:   return ARSH;
			default: return NOP;
		endcase
	endfunction

	task automatic issue(word_t w);
		@(posedge clk);
		instrValid <= 1'b1;
		instr      <= w;
	endtask

	task automatic idle(int cycles);
		int i;
		for (i = 0; i < cycles; i++)
		begin
			@(posedge clk);
			instrValid <= 1'b0;
			instr      <= word_t'(randBits(16));
		end
	endtask

	// Loads a full 16-bit value through r14 and r15
	task automatic loadWord(int r, word_t value);
		issue(immInstr(MAJOR_MOVI, r, value[15:8]));
		issue(immInstr(MAJOR_MOVI, 15, 8'd8));
		issue(regInstr(LSH, r, 15));
		issue(immInstr(MAJOR_MOVI, 14, value[7:0]));
		issue(regInstr(OR, r, 14));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic decoded_t expectDecode(word_t w);
		decoded_t d;
		opcode_t  code;
		d       = '0;
		d.rDest = w[11:8];
		d.rSrc  = w[3:0];
		code    = {w[15:12], w[7:4]};
		if (w[15:12] == MAJOR_ADDI)
		begin
			d.op          = ADD;
			d.useImm      = 1'b1;
			d.imm         = word_t'($signed(w[7:0]));
			d.writesReg   = 1'b1;
			d.writesFlags = 1'b1;
		end
		else if (w[15:12] == MAJOR_MOVI)
		begin
			d.passImm   = 1'b1;
			d.imm       = {8'h00, w[7:0]};
			d.writesReg = 1'b1;
		end
		else if (code == TEST || code == CMP)
		begin
			d.op          = code;
			d.writesFlags = 1'b1;
		end
		else if (code inside {AND, OR, XOR, ADD, ADDU, ADDCU, SUB, NOT,
			LSH, RSH, ALSH, ARSH})
		begin
			d.op          = code;
			d.writesReg   = 1'b1;
			d.writesFlags = 1'b1;
		end
		return d;
	endfunction

	function automatic aluOut_t refAlu(opcode_t op, word_t a, word_t b, logic cin);
		aluOut_t                   o;
		logic [`CPU16_DATA_WIDTH:0] wide;
		word_t                     nb;
		int                        i;
		o  = '0;
		nb = ~b + 1'b1;
		case (op)
			ADD:
			begin
				o.result         = a + b;
				o.flags.flag     = (a[msb] == b[msb]) && (o.result[msb] != a[msb]);
				o.flags.low      = $signed(a) < $signed(b);
				o.flags.negative = o.result[msb];
				o.flags.zero     = (o.result == 0);
			end
			ADDU, ADDCU:
			begin
				wide          = {1'b0, a} + {1'b0, b} + (op == ADDCU ? cin : 1'b0);
				o.result      = wide[msb:0];
				o.flags.carry = wide[msb+1];
				o.flags.low   = a < b;
				o.flags.zero  = (o.result == 0) && !(op == ADDCU && wide[msb+1]);
			end
			SUB:
			begin
				o.result         = a + nb;
				o.flags.flag     = (a[msb] == nb[msb]) && (o.result[msb] != a[msb]);
				o.flags.low      = $signed(a) < $signed(b);
				o.flags.negative = o.result[msb];
				o.flags.zero     = (a == b);
			end
			CMP, TEST:
			begin
				o.result         = (op == TEST) ? (a & b) : '0;
				o.flags.low      = a < b;
				o.flags.negative = $signed(a) < $signed(b);
				o.flags.zero     = (op == TEST) ? (o.result == 0) : (a == b);
			end
			AND, OR, XOR, NOT:
			begin
				if (op == AND)
					o.result = a & b;
				else if (op == OR)
					o.result = a | b;
				else if (op == XOR)
					o.result = a ^ b;
				else
					o.result = ~a;
				// NOT compares its result against A
				o.flags.low      = (op == NOT) ? (o.result < a) : (a < b);
				o.flags.negative = o.result[msb];
				o.flags.zero     = (o.result == 0);
			end
			LSH, ALSH, RSH:
			begin
				if (b >= `CPU16_DATA_WIDTH)
					o.result = '0;
				else if (op == RSH)
					o.result = a >> b[3:0];
				else
					o.result = a << b[3:0];
				o.flags.zero = (o.result == 0);
			end
			ARSH:
			begin
				o.result = a;
				for (i = 0; i < int'(b[3:0]); i++)
					o.result = {o.result[msb], o.result[msb:1]};
				o.flags.zero = (o.result == 0);
			end
			default:
			begin
				o = '0;
			end
		endcase
		return o;
	endfunction

	task automatic modelStep(word_t w);
		decoded_t d;
		word_t    opA;
		word_t    opB;
		aluOut_t  out;
		d   = expectDecode(w);
		opA = regModel[d.rDest];
		opB = d.useImm ? d.imm : regModel[d.rSrc];
		out = refAlu(d.op, opA, opB, expected.psr.carry);
		expected.valid = 1'b1;
		expected.write = d.writesReg;
		expected.addr  = d.rDest;
		expected.data  = d.passImm ? d.imm : out.result;
		if (d.writesReg)
			regModel[d.rDest] = expected.data;
		if (d.writesFlags)
			expected.psr = out.flags;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Comparison
	////////////////////////////////////////////////////////////////////////////

	task automatic checkValue(string name, logic [31:0] want, logic [31:0] got);
		assert (got === want)
		else
		begin
			$display("FAILED at %0t ns: %s expected %h, got %h", $time, name, want, got);
			errorCount++;
			$display("FAIL: see errors above");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	// Outputs settle after the rising edge so sample on the falling one
	always @(negedge clk)
	begin
		if (arstN)
		begin
			checkValue("wbValid", expected.valid, wbValid);
			checkValue("wbWrite", expected.write, wbWrite);
			checkValue("psr", expected.psr, psr);
			if (expected.valid)
			begin
				checkValue("wbAddr", expected.addr, wbAddr);
				checkValue("wbData", expected.data, wbData);
			end
			if (instrValid)
				modelStep(instr);
			else
			begin
				expected.valid = 1'b0;
				expected.write = 1'b0;
			end
		end
	end

	initial
	begin
		#(cycleBudget * clkPeriod);
		$display("ERROR: run did not finish within %0d cycles", cycleBudget);
		$display("FAIL: see errors above");
		$fatal(1, "Watchdog timeout");
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int         r;
		int         i;
		logic [3:0] sel;
		arstN      = 1'b0;
		instrValid = 1'b0;
		instr      = '0;
		lfsrState  = 32'h50a80c7f;
		errorCount = 0;
		expected   = '0;
		for (r = 0; r < `CPU16_REG_COUNT; r++)
			regModel[r] = '0;
		repeat (8) @(posedge clk);
		arstN <= 1'b1;
		idle(2);

		// Every register reads zero after reset
		for (r = 0; r < `CPU16_REG_COUNT; r++)
			issue(regInstr(OR, r, r));

		// MOVI to every register with r0 last as zero before reading back through ADD
		for (r = 15; r >= 1; r--)
			issue(immInstr(MAJOR_MOVI, r, 8'(randBits(8))));
		issue(immInstr(MAJOR_MOVI, 0, 8'h00));
		for (r = 1; r < `CPU16_REG_COUNT; r++)
			issue(regInstr(ADD, r, 0));

		for (r = 0; r < 14; r++)
			loadWord(r, word_t'(randBits(16)));

		// Carry chains into ADDCU
		// The first ADDU always carries out
		loadWord(1, 16'hC000);
		loadWord(2, 16'h8000);
		issue(regInstr(ADDU, 1, 2));
		issue(regInstr(ADDCU, 3, 4));
		issue(regInstr(SUB, 5, 6));
		issue(regInstr(ADDCU, 7, 8));

		// Idle cycles, NOP and undefined words
		idle(3);
		issue(regInstr(NOP, 1, 2));
		issue(16'h1234);
		issue(16'h0040);
		issue(16'h8000);
		issue(16'hF0F0);

		// Each shift op meets each amount 0 to 20 held in r13
		for (i = 0; i < shiftCount; i++)
		begin
			r = int'(randBits(4)) % 13;
			loadWord(r, word_t'(randBits(16)));
			issue(immInstr(MAJOR_MOVI, 13, 8'(i % 21)));
			issue(regInstr(pickRegOp(4'(10 + i % 4)), r, 13));
		end

		for (i = 0; i < randomCount; i++)
		begin
			if (randBits(2) == 0)
				idle(1);
			sel = 4'(randBits(4));
			if (randBits(4) == 0)
				issue(word_t'(randBits(16)));
			else if (sel < 14)
				issue(regInstr(pickRegOp(sel), randBits(4), randBits(4)));
			else if (sel == 14)
				issue(immInstr(MAJOR_ADDI, randBits(4), 8'(randBits(8))));
			else
				issue(immInstr(MAJOR_MOVI, randBits(4), 8'(randBits(8))));
		end
		idle(3);

		if (errorCount == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* cpu16Pkg.sv */
`default_nettype none

`include "cpu16_settings.svh"

package cpu16Pkg;

	typedef logic [`CPU16_DATA_WIDTH-1:0] word_t;
	typedef logic [$clog2(`CPU16_REG_COUNT)-1:0] regAddr_t;

	// Major field in the upper nibble, extension field in the lower
	typedef logic [7:0] opcode_t;

	////////////////////////////////////////////////////////////////////////////
	// ALU operation codes
	////////////////////////////////////////////////////////////////////////////
	localparam opcode_t NOP   = 8'h00;
	localparam opcode_t AND   = 8'h01;
	localparam opcode_t OR    = 8'h02;
	localparam opcode_t XOR   = 8'h03;
	localparam opcode_t ADD   = 8'h05;
	localparam opcode_t ADDU  = 8'h06;
	localparam opcode_t ADDCU = 8'h07;
	localparam opcode_t TEST  = 8'h08;
	localparam opcode_t SUB   = 8'h09;
	localparam opcode_t NOT   = 8'h0A;
	localparam opcode_t CMP   = 8'h0B;
	localparam opcode_t LSH   = 8'h84;
	localparam opcode_t RSH   = 8'h85;
	localparam opcode_t ALSH  = 8'h86;
	localparam opcode_t ARSH  = 8'h87;

	// Immediate forms, selected by the major field alone
	localparam logic [3:0] MAJOR_ADDI = 4'h5;
	localparam logic [3:0] MAJOR_MOVI = 4'hD;

	// Processor status bits, also the ALU flag outputs
	typedef struct packed {
		logic carry;
		logic flag;     // signed overflow
		logic low;
		logic negative;
		logic zero;
	} flags_t;

	typedef struct packed {
		opcode_t  op;
		regAddr_t rDest;
		regAddr_t rSrc;
		logic     useImm;
		logic     passImm;
		word_t    imm;
		logic     writesReg;
		logic     writesFlags;
	} decoded_t;

endpackage

`default_nettype wire

/* cpu16_settings.svh */
`ifndef CPU16_SETTINGS_SVH
`define CPU16_SETTINGS_SVH

// Datapath width in bits
`define CPU16_DATA_WIDTH 16

// Number of general purpose registers
`define CPU16_REG_COUNT 16

// Width of the immediate field in ADDI and MOVI
`define CPU16_IMM_WIDTH 8

`endif

/* instrDecoder.sv */
`default_nettype none
`timescale 1ns/10ps

`include "cpu16_settings.svh"

module instrDecoder (
	input  cpu16Pkg::word_t    instr,
	output cpu16Pkg::decoded_t decoded
);
	import cpu16Pkg::*;

	localparam int extWidth = `CPU16_DATA_WIDTH - `CPU16_IMM_WIDTH;

	logic [3:0]                  major;
	logic [`CPU16_IMM_WIDTH-1:0] immField;
	opcode_t                     regOp;

	assign major    = instr[15:12];
	assign immField = instr[`CPU16_IMM_WIDTH-1:0];
	// Major and extension nibbles form the register-register opcode
	assign regOp    = {major, instr[7:4]};

	always_comb
	begin
		decoded       = '0;
		decoded.op    = NOP;
		decoded.rDest = instr[11:8];
		decoded.rSrc  = instr[3:0];
		case (major)
			MAJOR_ADDI:
			begin
				decoded.op          = ADD;
				decoded.useImm      = 1'b1;
				decoded.imm         = {{extWidth{immField[`CPU16_IMM_WIDTH-1]}}, immField};
				decoded.writesReg   = 1'b1;
				decoded.writesFlags = 1'b1;
			end
			MAJOR_MOVI:
			begin
				decoded.passImm   = 1'b1;
				decoded.imm       = {{extWidth{1'b0}}, immField};
				decoded.writesReg = 1'b1;
			end
			default:
			begin
				// Only majors 0 and 8 can match a defined opcode here
				case (regOp)
					AND, OR, XOR, ADD, ADDU, ADDCU, SUB, NOT,
					LSH, RSH, ALSH, ARSH:
					begin
						decoded.op          = regOp;
						decoded.writesReg   = 1'b1;
						decoded.writesFlags = 1'b1;
					end
					TEST, CMP:
					begin
						decoded.op          = regOp;
						decoded.writesFlags = 1'b1;
					end
					default:
					begin
						decoded.op = NOP;
					end
				endcase
			end
		endcase
	end

endmodule

`default_nettype wire

/* regFile.sv */
`default_nettype none
`timescale 1ns/10ps

`include "cpu16_settings.svh"

module regFile (
	input  logic               clk,
	input  logic               arstN,
	input  cpu16Pkg::regAddr_t readAddrA,
	input  cpu16Pkg::regAddr_t readAddrB,
	output cpu16Pkg::word_t    readDataA,
	output cpu16Pkg::word_t    readDataB,
	input  logic               writeEn,
	input  cpu16Pkg::regAddr_t writeAddr,
	input  cpu16Pkg::word_t    writeData
);
	import cpu16Pkg::*;

	word_t regs [`CPU16_REG_COUNT];

	// Registers come up as zero after reset
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			regs <= '{default: '0};
		else if (writeEn)
			regs[writeAddr] <= writeData;
	end

	// Read ports see the value written at the previous edge
	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the cpu16Exec testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module cpu16Exec_tb -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv > "$log" 2>&1
status=$?
cat "$log"

if grep -q "FAIL: see errors above" "$log"; then
	echo "Simulation reported failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
echo "Simulation passed"
exit 0

/* sim.f */
+incdir+.
cpu16Pkg.sv
alu.sv
instrDecoder.sv
regFile.sv
writeback.sv
cpu16Exec.sv
cpu16Exec_chk.sv
cpu16Exec_tb.sv

/* writeback.sv */
`default_nettype none
`timescale 1ns/10ps

module writeback (
	input  logic               clk,
	input  logic               arstN,
	input  logic               instrValid,
	input  cpu16Pkg::decoded_t decoded,
	input  cpu16Pkg::word_t    aluResult,
	input  cpu16Pkg::flags_t   aluFlags,
	output logic               writeEn,
	output cpu16Pkg::regAddr_t writeAddr,
	output cpu16Pkg::word_t    writeData,
	output logic               wbValid,
	output logic               wbWrite,
	output cpu16Pkg::regAddr_t wbAddr,
	output cpu16Pkg::word_t    wbData,
	output cpu16Pkg::flags_t   psr
);

	////////////////////////////////////////////////////////////////////////////
	// Register file write, same edge as the strobe
	////////////////////////////////////////////////////////////////////////////

	// MOVI bypasses the ALU
	assign writeData = decoded.passImm ? decoded.imm : aluResult;
	assign writeAddr = decoded.rDest;
	assign writeEn   = instrValid && decoded.writesReg;

	////////////////////////////////////////////////////////////////////////////
	// Status register and writeback report
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			wbValid <= 1'b0;
			wbWrite <= 1'b0;
			psr     <= '0;
		end
		else
		begin
			wbValid <= instrValid;
			wbWrite <= writeEn;
			if (instrValid && decoded.writesFlags)
				psr <= aluFlags;
		end
	end

	// Report payload, only meaningful while wbValid is high
	always_ff @(posedge clk)
	begin
		if (instrValid)
		begin
			wbAddr <= writeAddr;
			wbData <= writeData;
		end
	end

endmodule

`default_nettype wire
